//--- include/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// --------------------
// datapath widths
// --------------------
`define XLEN 32
`define REG_IDX_W 5

// --------------------
// flow control
// --------------------

// issue queue entries
// the source also starts with one credit per entry
`define DEC_QUEUE_DEPTH 4

// credits held by the execute stage after reset
`define DEC_DOWN_CREDITS 2

`endif

//--- hdl/rv_isa_pkg.sv
`include "rv_decode_defs.svh"

package rv_isa_pkg;

    // major opcodes of the base integer set
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // --------------------
    // funct3 per class
    // --------------------
    localparam logic [2:0] F3_JALR = 3'b000;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } store_f3_e;

    // shared by OP and OP-IMM, F3_SR covers both right shifts
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_MUL    = 3'b000,
        F3_MULH   = 3'b001,
        F3_MULHSU = 3'b010,
        F3_MULHU  = 3'b011,
        F3_DIV    = 3'b100,
        F3_DIVU   = 3'b101,
        F3_REM    = 3'b110,
        F3_REMU   = 3'b111
    } muldiv_f3_e;

    // --------------------
    // funct7
    // --------------------
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // field view of a 32-bit instruction word
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        opcode_e               opcode;
    } instr_fields_t;

endpackage

//--- hdl/rv_decode_pkg.sv
`include "rv_decode_defs.svh"

package rv_decode_pkg;

    // one code per instruction the ALU sees
    typedef enum logic [5:0] {
        ALU_NONE,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI, ALU_ANDI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        BRA_NONE,
        BRA_BEQ,
        BRA_BNE,
        BRA_BLT,
        BRA_BGE,
        BRA_BLTU,
        BRA_BGEU
    } bra_op_e;

    // nine codes, so four bits
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT
    } imm_fmt_e;

    // --------------------
    // decode result
    // --------------------
    typedef struct packed {
        logic                  en_alu;
        logic                  en_branch;
        logic                  en_mem;
        alu_op_e               alu_op;
        bra_op_e               bra_op;
        mem_op_e               mem_op;
        logic                  mem_read;
        logic                  mem_write;
        logic                  rs1_read;
        logic                  rs2_read;
        logic                  rd_write;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      imm;
    } decoded_t;

endpackage

//--- hdl/rv_imm_gen.sv
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_imm_gen (
    input  logic [`XLEN-1:0]      instr_i,
    input  rv_decode_pkg::imm_fmt_e fmt_i,
    output logic [`XLEN-1:0]      imm_o
);

    import rv_decode_pkg::*;

    // sign comes from bit 31 in every format except the shift amount
    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{(`XLEN-11){instr_i[31]}}, instr_i[30:20]};
            end
            IMM_S: begin
                imm_o = {{(`XLEN-11){instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{(`XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            // shamt is unsigned
            IMM_SHAMT: begin
                imm_o = {{(`XLEN-5){1'b0}}, instr_i[24:20]};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/rv_decode_stage.sv
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    instr_valid_i,
    input  logic [`XLEN-1:0]        instr_i,
    output logic                    stage_valid_o,
    output rv_decode_pkg::decoded_t stage_dec_o
);

    import rv_isa_pkg::*;
    import rv_decode_pkg::*;

    // instruction classes, each fixes the flags and immediate format
    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_U,
        CLS_J,
        CLS_IMM,
        CLS_SHIFT,
        CLS_BR,
        CLS_LD,
        CLS_ST,
        CLS_REG
    } cls_e;

    typedef struct packed {
        cls_e    cls;
        alu_op_e alu;
        bra_op_e bra;
        mem_op_e mem;
    } row_t;

    logic             valid_q;
    logic [`XLEN-1:0] instr_q;
    instr_fields_t    fields;
    row_t             row;
    imm_fmt_e         fmt;
    logic [`XLEN-1:0] imm;

    // --------------------
    // input register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            instr_q <= instr_i;
        end
    end

    assign fields        = instr_fields_t'(instr_q);
    assign stage_valid_o = valid_q;

    // --------------------
    // classification
    // --------------------
    always_comb begin
        row = '{CLS_NONE, ALU_NONE, BRA_NONE, MEM_NONE};
        casez ({fields.funct7, fields.funct3, fields.opcode})
            {7'b???????, 3'b???, OPC_LUI}:      row = '{CLS_U, ALU_LUI, BRA_NONE, MEM_NONE};
            {7'b???????, 3'b???, OPC_AUIPC}:    row = '{CLS_U, ALU_AUIPC, BRA_NONE, MEM_NONE};
            {7'b???????, 3'b???, OPC_JAL}:      row = '{CLS_J, ALU_JAL, BRA_NONE, MEM_NONE};
            {7'b???????, F3_JALR, OPC_JALR}:    row = '{CLS_IMM, ALU_JALR, BRA_NONE, MEM_NONE};

            {7'b???????, F3_BEQ, OPC_BRANCH}:   row = '{CLS_BR, ALU_BEQ, BRA_BEQ, MEM_NONE};
            {7'b???????, F3_BNE, OPC_BRANCH}:   row = '{CLS_BR, ALU_BNE, BRA_BNE, MEM_NONE};
            {7'b???????, F3_BLT, OPC_BRANCH}:   row = '{CLS_BR, ALU_BLT, BRA_BLT, MEM_NONE};
            {7'b???????, F3_BGE, OPC_BRANCH}:   row = '{CLS_BR, ALU_BGE, BRA_BGE, MEM_NONE};
            {7'b???????, F3_BLTU, OPC_BRANCH}:  row = '{CLS_BR, ALU_BLTU, BRA_BLTU, MEM_NONE};
            {7'b???????, F3_BGEU, OPC_BRANCH}:  row = '{CLS_BR, ALU_BGEU, BRA_BGEU, MEM_NONE};

            {7'b???????, F3_LB, OPC_LOAD}:      row = '{CLS_LD, ALU_NONE, BRA_NONE, MEM_LB};
            {7'b???????, F3_LH, OPC_LOAD}:      row = '{CLS_LD, ALU_NONE, BRA_NONE, MEM_LH};
            {7'b???????, F3_LW, OPC_LOAD}:      row = '{CLS_LD, ALU_NONE, BRA_NONE, MEM_LW};
            {7'b???????, F3_LBU, OPC_LOAD}:     row = '{CLS_LD, ALU_NONE, BRA_NONE, MEM_LBU};
            {7'b???????, F3_LHU, OPC_LOAD}:     row = '{CLS_LD, ALU_NONE, BRA_NONE, MEM_LHU};
            {7'b???????, F3_SB, OPC_STORE}:     row = '{CLS_ST, ALU_NONE, BRA_NONE, MEM_SB};
            {7'b???????, F3_SH, OPC_STORE}:     row = '{CLS_ST, ALU_NONE, BRA_NONE, MEM_SH};
            {7'b???????, F3_SW, OPC_STORE}:     row = '{CLS_ST, ALU_NONE, BRA_NONE, MEM_SW};

            {7'b???????, F3_ADD, OPC_OP_IMM}:   row = '{CLS_IMM, ALU_ADDI, BRA_NONE, MEM_NONE};
            {7'b???????, F3_SLT, OPC_OP_IMM}:   row = '{CLS_IMM, ALU_SLTI, BRA_NONE, MEM_NONE};
            {7'b???????, F3_SLTU, OPC_OP_IMM}:  row = '{CLS_IMM, ALU_SLTIU, BRA_NONE, MEM_NONE};
            {7'b???????, F3_XOR, OPC_OP_IMM}:   row = '{CLS_IMM, ALU_XORI, BRA_NONE, MEM_NONE};
            {7'b???????, F3_OR, OPC_OP_IMM}:    row = '{CLS_IMM, ALU_ORI, BRA_NONE, MEM_NONE};
            {7'b???????, F3_AND, OPC_OP_IMM}:   row = '{CLS_IMM, ALU_ANDI, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SLL, OPC_OP_IMM}:      row = '{CLS_SHIFT, ALU_SLLI, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SR, OPC_OP_IMM}:       row = '{CLS_SHIFT, ALU_SRLI, BRA_NONE, MEM_NONE};
            {F7_ALT, F3_SR, OPC_OP_IMM}:        row = '{CLS_SHIFT, ALU_SRAI, BRA_NONE, MEM_NONE};

            {F7_BASE, F3_ADD, OPC_OP}:          row = '{CLS_REG, ALU_ADD, BRA_NONE, MEM_NONE};
            {F7_ALT, F3_ADD, OPC_OP}:           row = '{CLS_REG, ALU_SUB, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SLL, OPC_OP}:          row = '{CLS_REG, ALU_SLL, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SLT, OPC_OP}:          row = '{CLS_REG, ALU_SLT, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SLTU, OPC_OP}:         row = '{CLS_REG, ALU_SLTU, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_XOR, OPC_OP}:          row = '{CLS_REG, ALU_XOR, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_SR, OPC_OP}:           row = '{CLS_REG, ALU_SRL, BRA_NONE, MEM_NONE};
            {F7_ALT, F3_SR, OPC_OP}:            row = '{CLS_REG, ALU_SRA, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_OR, OPC_OP}:           row = '{CLS_REG, ALU_OR, BRA_NONE, MEM_NONE};
            {F7_BASE, F3_AND, OPC_OP}:          row = '{CLS_REG, ALU_AND, BRA_NONE, MEM_NONE};

            // M extension
            {F7_MULDIV, F3_MUL, OPC_OP}:        row = '{CLS_REG, ALU_MUL, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_MULH, OPC_OP}:       row = '{CLS_REG, ALU_MULH, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_MULHSU, OPC_OP}:     row = '{CLS_REG, ALU_MULHSU, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_MULHU, OPC_OP}:      row = '{CLS_REG, ALU_MULHU, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_DIV, OPC_OP}:        row = '{CLS_REG, ALU_DIV, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_DIVU, OPC_OP}:       row = '{CLS_REG, ALU_DIVU, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_REM, OPC_OP}:        row = '{CLS_REG, ALU_REM, BRA_NONE, MEM_NONE};
            {F7_MULDIV, F3_REMU, OPC_OP}:       row = '{CLS_REG, ALU_REMU, BRA_NONE, MEM_NONE};
            default: begin
                row = '{CLS_NONE, ALU_NONE, BRA_NONE, MEM_NONE};
            end
        endcase
    end

    // immediate format per class
    always_comb begin
        case (row.cls)
            CLS_U:           fmt = IMM_U;
            CLS_J:           fmt = IMM_J;
            CLS_IMM, CLS_LD: fmt = IMM_I;
            CLS_SHIFT:       fmt = IMM_SHAMT;
            CLS_BR:          fmt = IMM_B;
            CLS_ST:          fmt = IMM_S;
            default:         fmt = IMM_NONE;
        endcase
    end

    rv_imm_gen rv_imm_gen_i (
        .instr_i (instr_q),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    // --------------------
    // flags and fields
    // --------------------
    always_comb begin
        stage_dec_o           = '0;
        stage_dec_o.en_alu    = (row.cls != CLS_NONE);
        stage_dec_o.en_branch = (row.cls == CLS_BR);
        stage_dec_o.en_mem    = (row.cls inside {CLS_LD, CLS_ST});
        stage_dec_o.alu_op    = row.alu;
        stage_dec_o.bra_op    = row.bra;
        stage_dec_o.mem_op    = row.mem;
        stage_dec_o.mem_read  = (row.cls == CLS_LD);
        stage_dec_o.mem_write = (row.cls == CLS_ST);
        stage_dec_o.rs1_read  = (row.cls inside {CLS_IMM, CLS_SHIFT, CLS_BR,
                                                 CLS_LD, CLS_ST, CLS_REG});
        stage_dec_o.rs2_read  = (row.cls inside {CLS_BR, CLS_ST, CLS_REG});
        stage_dec_o.rd_write  = (row.cls inside {CLS_U, CLS_J, CLS_IMM,
                                                 CLS_SHIFT, CLS_LD, CLS_REG});
        // unknown encodings keep zero indices too
        if (row.cls != CLS_NONE) begin
            stage_dec_o.rs1 = fields.rs1;
            stage_dec_o.rs2 = fields.rs2;
            stage_dec_o.rd  = fields.rd;
        end
        stage_dec_o.imm = imm;
    end

endmodule

//--- hdl/rv_issue_queue.sv
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_issue_queue #(
    parameter int DEPTH        = `DEC_QUEUE_DEPTH,
    parameter int DOWN_CREDITS = `DEC_DOWN_CREDITS
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    wr_valid_i,
    input  rv_decode_pkg::decoded_t wr_dec_i,
    output logic                    credit_o,
    output logic                    dec_valid_o,
    output rv_decode_pkg::decoded_t dec_o,
    input  logic                    down_credit_i
);

    import rv_decode_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(DOWN_CREDITS + 1);

    decoded_t         mem_q [DEPTH];
    decoded_t         out_q;
    logic             out_valid_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] down_cnt_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // head leaves only while the execute stage holds a credit
    assign pop = (count_q != '0) && (down_cnt_q != '0);

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            mem_q[wr_ptr_q] <= wr_dec_i;
        end
        if (pop) begin
            out_q <= mem_q[rd_ptr_q];
        end
    end

    // --------------------
    // pointers and credits
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            down_cnt_q  <= CRD_W'(DOWN_CREDITS);
            out_valid_q <= 1'b0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q     <= count_q + CNT_W'(wr_valid_i) - CNT_W'(pop);
            // return and spend may land in the same cycle
            down_cnt_q  <= down_cnt_q + CRD_W'(down_credit_i) - CRD_W'(pop);
            out_valid_q <= pop;
        end
    end

    // a popped slot goes back to the source with the entry
    assign dec_valid_o = out_valid_q;
    assign credit_o    = out_valid_q;
    assign dec_o       = out_q;

endmodule

//--- hdl/rv32im_decode_unit.sv
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv32im_decode_unit #(
    parameter int DOWN_CREDITS = `DEC_DOWN_CREDITS
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    instr_valid_i,
    input  logic [`XLEN-1:0]        instr_i,
    output logic                    credit_o,
    output logic                    dec_valid_o,
    output rv_decode_pkg::decoded_t dec_o,
    input  logic                    down_credit_i
);

    import rv_decode_pkg::*;

    // decode stage to queue
    logic     stage_valid;
    decoded_t stage_dec;

    rv_decode_stage rv_decode_stage_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stage_valid_o (stage_valid),
        .stage_dec_o   (stage_dec)
    );

    // source credits guarantee a free slot, so no stall path
    rv_issue_queue #(
        .DEPTH        (`DEC_QUEUE_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) rv_issue_queue_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wr_valid_i    (stage_valid),
        .wr_dec_i      (stage_dec),
        .credit_o      (credit_o),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .down_credit_i (down_credit_i)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- dv/tb_rv32im_decode_unit.sv
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module tb_rv32im_decode_unit;

    import rv_decode_pkg::*;

    localparam int DOWN_CREDITS = `DEC_DOWN_CREDITS;
    localparam int SRC_CREDITS  = `DEC_QUEUE_DEPTH;
    localparam int TIMEOUT      = 2000;

    logic             clk;
    logic             rst;
    logic             instr_valid = 1'b0;
    logic [`XLEN-1:0] instr       = '0;
    logic             down_credit = 1'b0;
    logic             credit;
    logic             dec_valid;
    decoded_t         dec;

    // stimulus and expected results, one row per instruction
    string            tbl_name  [$];
    logic [`XLEN-1:0] tbl_instr [$];
    decoded_t         tbl_exp   [$];

    int   sent       = 0;
    int   out_cnt    = 0;
    int   credit_cnt = 0;
    int   returned   = 0;
    int   gap        = 0;
    logic driving    = 1'b0;
    logic hold_down  = 1'b1;

    tb_clk_gen tb_clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv32im_decode_unit #(
        .DOWN_CREDITS (DOWN_CREDITS)
    ) rv32im_decode_unit_i (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .credit_o      (credit),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec),
        .down_credit_i (down_credit)
    );

    // --------------------
    // checks
    // --------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_dec(input string name, input decoded_t exp, input decoded_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_credits(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_with_failure($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // --------------------
    // table rows
    // --------------------
    task automatic add_row(input string name, input logic [31:0] w, input decoded_t exp,
                           input logic known);
        if (known) begin
            exp.rs1 = w[19:15];
            exp.rs2 = w[24:20];
            exp.rd  = w[11:7];
        end
        tbl_name.push_back(name);
        tbl_instr.push_back(w);
        tbl_exp.push_back(exp);
    endtask

    task automatic add_reg(input string name, input alu_op_e op, input logic [6:0] f7,
                           input logic [2:0] f3);
        decoded_t   e;
        logic [4:0] n;
        n          = 5'(tbl_instr.size());
        e          = '0;
        e.en_alu   = 1'b1;
        e.alu_op   = op;
        e.rs1_read = 1'b1;
        e.rs2_read = 1'b1;
        e.rd_write = 1'b1;
        add_row(name, {f7, n + 5'd7, ~n, f3, n + 5'd1, 7'b0110011}, e, 1'b1);
    endtask

    // OP-IMM and JALR
    task automatic add_imm(input string name, input alu_op_e op, input logic [2:0] f3,
                           input int imm, input logic [6:0] opc);
        decoded_t    e;
        logic [4:0]  n;
        logic [31:0] iv;
        n          = 5'(tbl_instr.size());
        iv         = imm;
        e          = '0;
        e.en_alu   = 1'b1;
        e.alu_op   = op;
        e.rs1_read = 1'b1;
        e.rd_write = 1'b1;
        e.imm      = iv;
        add_row(name, {iv[11:0], ~n, f3, n + 5'd1, opc}, e, 1'b1);
    endtask

    task automatic add_shift(input string name, input alu_op_e op, input logic [6:0] f7,
                             input logic [2:0] f3, input logic [4:0] shamt);
        decoded_t   e;
        logic [4:0] n;
        n          = 5'(tbl_instr.size());
        e          = '0;
        e.en_alu   = 1'b1;
        e.alu_op   = op;
        e.rs1_read = 1'b1;
        e.rd_write = 1'b1;
        e.imm      = {27'b0, shamt};
        add_row(name, {f7, shamt, ~n, f3, n + 5'd1, 7'b0010011}, e, 1'b1);
    endtask

    task automatic add_mem(input string name, input mem_op_e op, input logic [2:0] f3,
                           input int imm, input logic is_store);
        decoded_t    e;
        logic [4:0]  n;
        logic [31:0] iv;
        n          = 5'(tbl_instr.size());
        iv         = imm;
        e          = '0;
        e.en_alu   = 1'b1;
        e.en_mem   = 1'b1;
        e.mem_op   = op;
        e.rs1_read = 1'b1;
        e.imm      = iv;
        if (is_store) begin
            e.mem_write = 1'b1;
            e.rs2_read  = 1'b1;
            add_row(name, {iv[11:5], n + 5'd7, ~n, f3, iv[4:0], 7'b0100011}, e, 1'b1);
        end else begin
            e.mem_read = 1'b1;
            e.rd_write = 1'b1;
            add_row(name, {iv[11:0], ~n, f3, n + 5'd1, 7'b0000011}, e, 1'b1);
        end
    endtask

    task automatic add_branch(input string name, input alu_op_e aop, input bra_op_e bop,
                              input logic [2:0] f3, input int imm);
        decoded_t    e;
        logic [4:0]  n;
        logic [31:0] iv;
        n           = 5'(tbl_instr.size());
        iv          = imm;
        e           = '0;
        e.en_alu    = 1'b1;
        e.en_branch = 1'b1;
        e.alu_op    = aop;
        e.bra_op    = bop;
        e.rs1_read  = 1'b1;
        e.rs2_read  = 1'b1;
        e.imm       = iv;
        add_row(name, {iv[12], iv[10:5], n + 5'd7, ~n, f3, iv[4:1], iv[11], 7'b1100011},
                e, 1'b1);
    endtask

    // LUI, AUIPC and JAL
    task automatic add_upper(input string name, input alu_op_e op, input logic [6:0] opc,
                             input logic [31:0] iv);
        decoded_t    e;
        logic [4:0]  n;
        logic [31:0] w;
        n          = 5'(tbl_instr.size());
        e          = '0;
        e.en_alu   = 1'b1;
        e.alu_op   = op;
        e.rd_write = 1'b1;
        if (op == ALU_JAL) begin
            e.imm = iv;
            w     = {iv[20], iv[10:1], iv[11], iv[19:12], n + 5'd1, opc};
        end else begin
            e.imm = {iv[31:12], 12'b0};
            w     = {iv[31:12], n + 5'd1, opc};
        end
        add_row(name, w, e, 1'b1);
    endtask

    task automatic build_table();
        add_reg("ADD", ALU_ADD, 7'b0000000, 3'b000);
        add_reg("SUB", ALU_SUB, 7'b0100000, 3'b000);
        add_reg("SLL", ALU_SLL, 7'b0000000, 3'b001);
        add_reg("SLT", ALU_SLT, 7'b0000000, 3'b010);
        add_reg("SLTU", ALU_SLTU, 7'b0000000, 3'b011);
        add_reg("XOR", ALU_XOR, 7'b0000000, 3'b100);
        add_reg("SRL", ALU_SRL, 7'b0000000, 3'b101);
        add_reg("SRA", ALU_SRA, 7'b0100000, 3'b101);
        add_reg("OR", ALU_OR, 7'b0000000, 3'b110);
        add_reg("AND", ALU_AND, 7'b0000000, 3'b111);
        add_row("bad funct7", {7'b1000000, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011}, '0, 1'b0);
        add_reg("MUL", ALU_MUL, 7'b0000001, 3'b000);
        add_reg("MULH", ALU_MULH, 7'b0000001, 3'b001);
        add_reg("MULHSU", ALU_MULHSU, 7'b0000001, 3'b010);
        add_reg("MULHU", ALU_MULHU, 7'b0000001, 3'b011);
        add_reg("DIV", ALU_DIV, 7'b0000001, 3'b100);
        add_reg("DIVU", ALU_DIVU, 7'b0000001, 3'b101);
        add_reg("REM", ALU_REM, 7'b0000001, 3'b110);
        add_reg("REMU", ALU_REMU, 7'b0000001, 3'b111);
        add_imm("ADDI", ALU_ADDI, 3'b000, -5, 7'b0010011);
        add_imm("SLTI", ALU_SLTI, 3'b010, 100, 7'b0010011);
        add_imm("SLTIU", ALU_SLTIU, 3'b011, 2047, 7'b0010011);
        add_imm("XORI", ALU_XORI, 3'b100, -1, 7'b0010011);
        add_imm("ORI", ALU_ORI, 3'b110, 'h555, 7'b0010011);
        add_imm("ANDI", ALU_ANDI, 3'b111, -2048, 7'b0010011);
        add_imm("JALR", ALU_JALR, 3'b000, 12, 7'b1100111);
        add_shift("SLLI", ALU_SLLI, 7'b0000000, 3'b001, 5'd7);
        add_shift("SRLI", ALU_SRLI, 7'b0000000, 3'b101, 5'd17);
        // bit 30 set so an I immediate would differ
        add_shift("SRAI", ALU_SRAI, 7'b0100000, 3'b101, 5'd31);
        add_row("SLLI alt funct7", {7'b0100000, 5'd4, 5'd2, 3'b001, 5'd1, 7'b0010011},
                '0, 1'b0);
        add_mem("LB", MEM_LB, 3'b000, -4, 1'b0);
        add_mem("LH", MEM_LH, 3'b001, 2, 1'b0);
        add_mem("LW", MEM_LW, 3'b010, 2047, 1'b0);
        add_mem("LBU", MEM_LBU, 3'b100, 0, 1'b0);
        add_mem("LHU", MEM_LHU, 3'b101, -2048, 1'b0);
        add_row("load funct3 3", {12'h010, 5'd2, 3'b011, 5'd1, 7'b0000011}, '0, 1'b0);
        add_mem("SB", MEM_SB, 3'b000, 5, 1'b1);
        add_mem("SH", MEM_SH, 3'b001, -1, 1'b1);
        add_mem("SW", MEM_SW, 3'b010, -12, 1'b1);
        add_branch("BEQ", ALU_BEQ, BRA_BEQ, 3'b000, 8);
        add_branch("BNE", ALU_BNE, BRA_BNE, 3'b001, -16);
        add_branch("BLT", ALU_BLT, BRA_BLT, 3'b100, 4094);
        add_branch("BGE", ALU_BGE, BRA_BGE, 3'b101, -4096);
        add_branch("BLTU", ALU_BLTU, BRA_BLTU, 3'b110, 2);
        add_branch("BGEU", ALU_BGEU, BRA_BGEU, 3'b111, 2048);
        add_upper("LUI", ALU_LUI, 7'b0110111, 32'hABCD_E000);
        add_upper("AUIPC", ALU_AUIPC, 7'b0010111, 32'h0000_1000);
        add_upper("JAL back", ALU_JAL, 7'b1101111, 32'hFFFF_F800);
        add_upper("JAL fwd", ALU_JAL, 7'b1101111, 32'h000F_FFFE);
        add_row("all ones", 32'hFFFF_FFFF, '0, 1'b0);
    endtask

    // --------------------
    // source side
    // --------------------
    always @(posedge clk) begin
        if (rst || !driving) begin
            instr_valid <= 1'b0;
        end else if (sent < tbl_instr.size() && gap == 0 && sent - credit_cnt < SRC_CREDITS) begin
            instr_valid <= 1'b1;
            instr       <= tbl_instr[sent];
            sent        <= sent + 1;
            gap         <= $urandom % 3;
        end else begin
            // idle cycles carry junk that must not be latched
            instr_valid <= 1'b0;
            instr       <= $urandom;
            if (gap > 0) begin
                gap <= gap - 1;
            end
        end
    end

    // execute side returns a credit for each entry it got
    always @(posedge clk) begin
        if (rst || hold_down || out_cnt == returned) begin
            down_credit <= 1'b0;
        end else if (($urandom % 4) != 0) begin
            down_credit <= 1'b1;
            returned    <= returned + 1;
        end else begin
            down_credit <= 1'b0;
        end
    end

    // --------------------
    // output monitor
    // --------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (dec_valid === 1'b1) begin
                if (out_cnt >= tbl_exp.size()) begin
                    stop_with_failure("an output arrived with no instruction outstanding");
                end else begin
                    check_dec(tbl_name[out_cnt], tbl_exp[out_cnt], dec);
                end
                out_cnt = out_cnt + 1;
            end
            if (credit === 1'b1) begin
                credit_cnt = credit_cnt + 1;
            end
            check_credits("credit_o pulses against outputs", out_cnt, credit_cnt);
        end
    end

    initial begin
        int seed_ret;
        int cycles;
        seed_ret = $urandom(32'h76c3f0f5);
        build_table();

        cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > 100) begin
                stop_with_failure("reset was never released");
            end
        end
        if (dec_valid !== 1'b0 || credit !== 1'b0) begin
            stop_with_failure("dec_valid_o or credit_o is not low after reset");
        end

        // --------------------
        // back-pressure first
        // --------------------
        driving <= 1'b1;
        cycles = 0;
        while (sent < SRC_CREDITS + DOWN_CREDITS) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                stop_with_failure("the source never used up its credits under back-pressure");
            end
        end
        repeat (20) @(posedge clk);
        check_credits("back-pressure outputs", DOWN_CREDITS, out_cnt);

        // the rest drains in order once credits resume
        hold_down <= 1'b0;
        cycles = 0;
        while (out_cnt < tbl_exp.size()) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                stop_with_failure("not every instruction came out of the unit");
            end
        end
        repeat (5) @(posedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/rv_decode_pkg.sv
hdl/rv_imm_gen.sv
hdl/rv_decode_stage.sv
hdl/rv_issue_queue.sv
hdl/rv32im_decode_unit.sv
dv/tb_clk_gen.sv
dv/tb_rv32im_decode_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rv32im_decode_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a non-zero exit
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
